/* harness_top.f */
+incdir+source
source/harness_pkg.sv
source/reset_debug_ctrl.sv
source/bus_demux.sv
source/boot_rom.sv
source/sram_bank.sv
source/sys_regs.sv
source/harness_top.sv
sim/harness_tb.sv

/* sim/harness_tb.sv */
// --------------------
// Testbench for the harness top level
// Runs four-phase bus transfers against a memory and register model
// --------------------

`timescale 1ns/100ps
`include "harness_config.svh"

module harness_tb;

  import harness_pkg::*;

  localparam int unsigned ack_timeout = 20;
  localparam int unsigned irq_timeout = 200;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       rtc_i;
  logic                       ndmreset_i;
  logic                       debug_req_i;
  logic                       debug_en_i;
  logic                       req_i;
  logic                       we_i;
  logic [`HARNESS_ADDR_W-1:0] addr_i;
  logic [`HARNESS_DATA_W-1:0] wdata_i;
  logic [`HARNESS_BE_W-1:0]   be_i;
  logic                       ack_o;
  logic                       err_o;
  logic [`HARNESS_DATA_W-1:0] rdata_o;
  logic                       timer_irq_o;
  logic                       ipi_o;
  logic                       exit_valid_o;
  logic [`HARNESS_DATA_W-2:0] exit_o;
  logic                       debug_req_o;

  // Model state
  logic [`HARNESS_DATA_W-1:0] sram_model [`HARNESS_SRAM_WORDS];
  logic                       msip_model;
  logic [`HARNESS_DATA_W-1:0] mtimecmp_model;
  tohost_u                    tohost_model;

  int unsigned err_count;
  int unsigned test_count;
  int unsigned test_fail_count;
  int unsigned errs_at_start;
  string       cur_test;

  harness_top i_harness_top (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .rtc_i        ( rtc_i        ),
    .ndmreset_i   ( ndmreset_i   ),
    .debug_req_i  ( debug_req_i  ),
    .debug_en_i   ( debug_en_i   ),
    .req_i        ( req_i        ),
    .we_i         ( we_i         ),
    .addr_i       ( addr_i       ),
    .wdata_i      ( wdata_i      ),
    .be_i         ( be_i         ),
    .ack_o        ( ack_o        ),
    .err_o        ( err_o        ),
    .rdata_o      ( rdata_o      ),
    .timer_irq_o  ( timer_irq_o  ),
    .ipi_o        ( ipi_o        ),
    .exit_valid_o ( exit_valid_o ),
    .exit_o       ( exit_o       ),
    .debug_req_o  ( debug_req_o  )
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // --------------------
  // Reference model
  // --------------------
  function automatic logic [`HARNESS_ADDR_W-1:0] make_addr(input logic [3:0] region,
                                                           input int unsigned idx);
    bus_addr_u ad;
    ad.f.region = region;
    ad.f.index  = `HARNESS_INDEX_W'(idx);
    ad.f.offset = '0;
    return ad.word;
  endfunction

  // Expected {err, rdata} of one transfer; mtime is checked by range instead
  function automatic logic [`HARNESS_DATA_W:0] ref_resp(input logic we,
                                                        input logic [`HARNESS_ADDR_W-1:0] addr);
    bus_addr_u                ad;
    logic [`HARNESS_DATA_W:0] r;
    ad.word = addr;
    r       = '0;
    case (ad.f.region)
      `HARNESS_REGION_ROM: begin
        if (we) r[`HARNESS_DATA_W] = 1'b1;
        else    r[`HARNESS_DATA_W-1:0] = BOOT_IMAGE[ad.f.index % `HARNESS_ROM_WORDS];
      end
      `HARNESS_REGION_SRAM: begin
        if (!we) r[`HARNESS_DATA_W-1:0] = sram_model[ad.f.index % `HARNESS_SRAM_WORDS];
      end
      `HARNESS_REGION_SYS: begin
        case (ad.f.index)
          `HARNESS_OFS_MSIP:     if (!we) r[0] = msip_model;
          `HARNESS_OFS_MTIMECMP: if (!we) r[`HARNESS_DATA_W-1:0] = mtimecmp_model;
          `HARNESS_OFS_MTIME:    r = '0;
          `HARNESS_OFS_TOHOST:   if (!we) r[`HARNESS_DATA_W-1:0] = tohost_model.raw;
          default:               r[`HARNESS_DATA_W] = 1'b1;
        endcase
      end
      default: r[`HARNESS_DATA_W] = 1'b1;
    endcase
    return r;
  endfunction

  task automatic update_model(input logic [`HARNESS_ADDR_W-1:0] addr,
                              input logic [`HARNESS_DATA_W-1:0] wdata,
                              input logic [`HARNESS_BE_W-1:0]   be);
    bus_addr_u ad;
    tohost_u   th;
    ad.word = addr;
    th.raw  = wdata;
    if (ad.f.region == `HARNESS_REGION_SRAM) begin
      for (int b = 0; b < `HARNESS_BE_W; b++) begin
        if (be[b]) sram_model[ad.f.index % `HARNESS_SRAM_WORDS][8*b +: 8] = wdata[8*b +: 8];
      end
    end else if (ad.f.region == `HARNESS_REGION_SYS) begin
      case (ad.f.index)
        `HARNESS_OFS_MSIP:     msip_model = wdata[0];
        `HARNESS_OFS_MTIMECMP: mtimecmp_model = wdata;
        `HARNESS_OFS_TOHOST:   if (th.f.done) tohost_model = th;
        default: ;
      endcase
    end
  endtask

  // --------------------
  // Checking and bus tasks
  // --------------------
  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s %s: expected 0x%08h, actual 0x%08h", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test      = name;
    errs_at_start = err_count;
  endtask

  task automatic finish_test();
    test_count++;
    if (err_count == errs_at_start) begin
      $display("test %-14s passed", cur_test);
    end else begin
      test_fail_count++;
      $display("test %-14s failed with %0d mismatches", cur_test, err_count - errs_at_start);
    end
  endtask

  // Inputs change 2 ns after the rising edge, outputs are read there too
  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic bus_xfer(input logic we, input logic [`HARNESS_ADDR_W-1:0] addr,
                          input logic [`HARNESS_DATA_W-1:0] wdata,
                          input logic [`HARNESS_BE_W-1:0] be,
                          output logic [`HARNESS_DATA_W-1:0] rdata, output logic err);
    int unsigned n;
    rdata = '0;
    err   = 1'b0;
    next_cycle();
    we_i    = we;
    addr_i  = addr;
    wdata_i = wdata;
    be_i    = be;
    req_i   = 1'b1;
    n       = 0;
    do begin
      next_cycle();
      n++;
    end while (!ack_o && n < ack_timeout);
    if (!ack_o) begin
      $display("Timeout: no ack from the bus at address 0x%04h", addr);
      err_count++;
    end else begin
      rdata = rdata_o;
      err   = err_o;
    end
    req_i = 1'b0;
    n     = 0;
    while (ack_o && n < ack_timeout) begin
      next_cycle();
      n++;
    end
    if (ack_o) begin
      $display("Timeout: ack stayed high after request dropped at address 0x%04h", addr);
      err_count++;
    end
  endtask

  task automatic bus_write(input logic [`HARNESS_ADDR_W-1:0] addr,
                           input logic [`HARNESS_DATA_W-1:0] wdata,
                           input logic [`HARNESS_BE_W-1:0]   be);
    logic [`HARNESS_DATA_W:0]   exp;
    logic [`HARNESS_DATA_W-1:0] rdata;
    logic                       err;
    exp = ref_resp(1'b1, addr);
    bus_xfer(1'b1, addr, wdata, be, rdata, err);
    check_eq($sformatf("write 0x%04h err", addr), exp[`HARNESS_DATA_W], err);
    check_eq($sformatf("write 0x%04h rdata", addr), exp[`HARNESS_DATA_W-1:0], rdata);
    update_model(addr, wdata, be);
  endtask

  task automatic bus_read(input logic [`HARNESS_ADDR_W-1:0] addr);
    logic [`HARNESS_DATA_W:0]   exp;
    logic [`HARNESS_DATA_W-1:0] rdata;
    logic                       err;
    exp = ref_resp(1'b0, addr);
    bus_xfer(1'b0, addr, '0, '0, rdata, err);
    check_eq($sformatf("read 0x%04h err", addr), exp[`HARNESS_DATA_W], err);
    check_eq($sformatf("read 0x%04h rdata", addr), exp[`HARNESS_DATA_W-1:0], rdata);
  endtask

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    logic [`HARNESS_DATA_W-1:0] rdata;
    logic [`HARNESS_DATA_W-1:0] mtime0;
    logic                       err;
    int unsigned                cycles;
    int unsigned                idx;
    int unsigned                idx_q[$];
    tohost_u                    th;

    void'($urandom(32'hbd78_0ef3));
    rst_ni      = 1'b0;
    rtc_i       = 1'b0;
    ndmreset_i  = 1'b0;
    debug_req_i = 1'b1;
    debug_en_i  = 1'b1;
    req_i       = 1'b0;
    we_i        = 1'b0;
    addr_i      = '0;
    wdata_i     = '0;
    be_i        = '0;
    err_count       = 0;
    test_count      = 0;
    test_fail_count = 0;
    msip_model      = 1'b0;
    mtimecmp_model  = '1;
    tohost_model    = '0;
    repeat (2) @(posedge clk_i);
    #2 rst_ni = 1'b1;

    start_test("debug_holdoff");
    cycles = 0;
    while (!debug_req_o && cycles < `HARNESS_DEBUG_HOLDOFF + 10) begin
      next_cycle();
      cycles++;
    end
    if (!debug_req_o) begin
      $display("Timeout: debug request never passed after power-on reset");
      err_count++;
    end
    check_eq("first debug cycle", `HARNESS_DEBUG_HOLDOFF, cycles);
    finish_test();

    // Full words first, then partial overwrites through aliased indexes
    start_test("sram");
    repeat (24) begin
      idx = $urandom_range(1023, 0);
      idx_q.push_back(idx);
      bus_write(make_addr(`HARNESS_REGION_SRAM, idx), $urandom, 4'hf);
    end
    repeat (24) begin
      idx = idx_q[$urandom_range(idx_q.size() - 1, 0)] ^ (256 * $urandom_range(3, 0));
      bus_write(make_addr(`HARNESS_REGION_SRAM, idx), $urandom, 4'($urandom));
    end
    foreach (idx_q[k]) begin
      bus_read(make_addr(`HARNESS_REGION_SRAM, idx_q[k]));
      bus_read(make_addr(`HARNESS_REGION_SRAM, idx_q[k] ^ 10'h100));
    end
    finish_test();

    start_test("boot_rom");
    for (int i = 0; i < `HARNESS_ROM_WORDS; i++) begin
      bus_read(make_addr(`HARNESS_REGION_ROM, i));
      bus_read(make_addr(`HARNESS_REGION_ROM, i + 3 * `HARNESS_ROM_WORDS));
    end
    bus_write(make_addr(`HARNESS_REGION_ROM, 5), 32'h1234_5678, 4'hf);
    bus_read(make_addr(`HARNESS_REGION_ROM, 5));
    finish_test();

    start_test("error_regions");
    bus_read(make_addr(`HARNESS_REGION_GPIO, 0));
    bus_write(make_addr(`HARNESS_REGION_GPIO, 1), 32'hffff_ffff, 4'hf);
    bus_read(make_addr(4'h1, 7));
    bus_read(make_addr(4'hf, 1023));
    bus_write(make_addr(`HARNESS_REGION_SRAM, 17), 32'h5a5a_0ff0, 4'hf);
    bus_read(make_addr(`HARNESS_REGION_SRAM, 17));
    finish_test();

    start_test("msip_timer");
    bus_write(make_addr(`HARNESS_REGION_SYS, `HARNESS_OFS_MSIP), 32'h1, 4'hf);
    check_eq("ipi_o set", 1, ipi_o);
    bus_read(make_addr(`HARNESS_REGION_SYS, `HARNESS_OFS_MSIP));
    bus_write(make_addr(`HARNESS_REGION_SYS, `HARNESS_OFS_MSIP), 32'h0, 4'hf);
    check_eq("ipi_o clear", 0, ipi_o);
    bus_xfer(1'b0, make_addr(`HARNESS_REGION_SYS, `HARNESS_OFS_MTIME), '0, '0, mtime0, err);
    check_eq("mtime read err", 0, err);
    bus_write(make_addr(`HARNESS_REGION_SYS, `HARNESS_OFS_MTIMECMP), mtime0 + 3, 4'hf);
    bus_read(make_addr(`HARNESS_REGION_SYS, `HARNESS_OFS_MTIMECMP));
    check_eq("timer_irq_o before ticks", 0, timer_irq_o);
    repeat (3) begin
      rtc_i = 1'b1;
      repeat (4) next_cycle();
      rtc_i = 1'b0;
      repeat (4) next_cycle();
    end
    cycles = 0;
    while (!timer_irq_o && cycles < irq_timeout) begin
      next_cycle();
      cycles++;
    end
    if (!timer_irq_o) begin
      $display("Timeout: timer interrupt did not rise after three rtc ticks");
      err_count++;
    end
    bus_xfer(1'b0, make_addr(`HARNESS_REGION_SYS, `HARNESS_OFS_MTIME), '0, '0, rdata, err);
    check_eq("mtime read err after ticks", 0, err);
    check_eq("mtime reached compare", 1, rdata >= mtime0 + 3);
    finish_test();

    start_test("tohost");
    th.f.code = 31'h15;
    th.f.done = 1'b0;
    bus_write(make_addr(`HARNESS_REGION_SYS, `HARNESS_OFS_TOHOST), th.raw, 4'hf);
    check_eq("exit_valid_o without done", 0, exit_valid_o);
    th.f.code = 31'h2a5;
    th.f.done = 1'b1;
    bus_write(make_addr(`HARNESS_REGION_SYS, `HARNESS_OFS_TOHOST), th.raw, 4'hf);
    check_eq("exit_valid_o with done", 1, exit_valid_o);
    check_eq("exit_o", 31'h2a5, exit_o);
    bus_read(make_addr(`HARNESS_REGION_SYS, `HARNESS_OFS_TOHOST));
    bus_read(make_addr(`HARNESS_REGION_SYS, 9));
    finish_test();

    start_test("debug_gating");
    debug_en_i = 1'b0;
    next_cycle();
    check_eq("debug_req_o disabled", 0, debug_req_o);
    debug_en_i = 1'b1;
    next_cycle();
    check_eq("debug_req_o enabled", 1, debug_req_o);
    bus_write(make_addr(`HARNESS_REGION_SYS, `HARNESS_OFS_MSIP), 32'h1, 4'hf);
    ndmreset_i = 1'b1;
    next_cycle();
    check_eq("ipi_o in ndmreset", 0, ipi_o);
    check_eq("exit_valid_o in ndmreset", 0, exit_valid_o);
    check_eq("debug_req_o in ndmreset", 1, debug_req_o);
    ndmreset_i = 1'b0;
    msip_model     = 1'b0;
    mtimecmp_model = '1;
    tohost_model   = '0;
    repeat (3) next_cycle();
    check_eq("debug_req_o after ndmreset", 1, debug_req_o);
    bus_read(make_addr(`HARNESS_REGION_SYS, `HARNESS_OFS_TOHOST));
    bus_read(make_addr(`HARNESS_REGION_SRAM, 17));
    finish_test();

    $display("Summary: %0d tests, %0d failed, %0d mismatches",
             test_count, test_fail_count, err_count);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* source/harness_top.sv */
// --------------------
// Top level of the simulation harness
// One external four-phase master reaches ROM, SRAM and system registers
// --------------------

`timescale 1ns/100ps
`include "harness_config.svh"

module harness_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       rtc_i,
  input  logic                       ndmreset_i,
  input  logic                       debug_req_i,
  input  logic                       debug_en_i,
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [`HARNESS_ADDR_W-1:0] addr_i,
  input  logic [`HARNESS_DATA_W-1:0] wdata_i,
  input  logic [`HARNESS_BE_W-1:0]   be_i,
  output logic                       ack_o,
  output logic                       err_o,
  output logic [`HARNESS_DATA_W-1:0] rdata_o,
  output logic                       timer_irq_o,
  output logic                       ipi_o,
  output logic                       exit_valid_o,
  output logic [`HARNESS_DATA_W-2:0] exit_o,
  output logic                       debug_req_o
);

  logic                       sys_rst_n;
  logic                       rom_req;
  logic                       sram_req;
  logic                       sys_req;
  logic                       bus_we;
  logic [`HARNESS_ADDR_W-1:0] bus_addr;
  logic [`HARNESS_DATA_W-1:0] bus_wdata;
  logic [`HARNESS_BE_W-1:0]   bus_be;
  logic                       rom_ack;
  logic                       rom_err;
  logic [`HARNESS_DATA_W-1:0] rom_rdata;
  logic                       sram_ack;
  logic                       sram_err;
  logic [`HARNESS_DATA_W-1:0] sram_rdata;
  logic                       sys_ack;
  logic                       sys_err;
  logic [`HARNESS_DATA_W-1:0] sys_rdata;

  // --------------------
  // Reset and debug
  // --------------------
  reset_debug_ctrl i_reset_debug_ctrl (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .ndmreset_i  ( ndmreset_i  ),
    .debug_req_i ( debug_req_i ),
    .debug_en_i  ( debug_en_i  ),
    .sys_rst_no  ( sys_rst_n   ),
    .debug_req_o ( debug_req_o )
  );

  // --------------------
  // Region decoder
  // --------------------
  bus_demux i_bus_demux (
    .clk_i        ( clk_i      ),
    .rst_ni       ( sys_rst_n  ),
    .req_i        ( req_i      ),
    .we_i         ( we_i       ),
    .addr_i       ( addr_i     ),
    .wdata_i      ( wdata_i    ),
    .be_i         ( be_i       ),
    .ack_o        ( ack_o      ),
    .rdata_o      ( rdata_o    ),
    .err_o        ( err_o      ),
    .rom_req_o    ( rom_req    ),
    .rom_ack_i    ( rom_ack    ),
    .rom_rdata_i  ( rom_rdata  ),
    .rom_err_i    ( rom_err    ),
    .sram_req_o   ( sram_req   ),
    .sram_ack_i   ( sram_ack   ),
    .sram_rdata_i ( sram_rdata ),
    .sram_err_i   ( sram_err   ),
    .sys_req_o    ( sys_req    ),
    .sys_ack_i    ( sys_ack    ),
    .sys_rdata_i  ( sys_rdata  ),
    .sys_err_i    ( sys_err    ),
    .we_o         ( bus_we     ),
    .addr_o       ( bus_addr   ),
    .wdata_o      ( bus_wdata  ),
    .be_o         ( bus_be     )
  );

  // --------------------
  // Targets
  // --------------------
  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .rst_ni  ( sys_rst_n ),
    .req_i   ( rom_req   ),
    .we_i    ( bus_we    ),
    .addr_i  ( bus_addr  ),
    .ack_o   ( rom_ack   ),
    .rdata_o ( rom_rdata ),
    .err_o   ( rom_err   )
  );

  // Power-on reset only, so contents and handshake survive ndmreset
  sram_bank i_sram_bank (
    .clk_i   ( clk_i      ),
    .rst_ni  ( rst_ni     ),
    .req_i   ( sram_req   ),
    .we_i    ( bus_we     ),
    .addr_i  ( bus_addr   ),
    .wdata_i ( bus_wdata  ),
    .be_i    ( bus_be     ),
    .ack_o   ( sram_ack   ),
    .rdata_o ( sram_rdata ),
    .err_o   ( sram_err   )
  );

  sys_regs i_sys_regs (
    .clk_i        ( clk_i        ),
    .rst_ni       ( sys_rst_n    ),
    .rtc_i        ( rtc_i        ),
    .req_i        ( sys_req      ),
    .we_i         ( bus_we       ),
    .addr_i       ( bus_addr     ),
    .wdata_i      ( bus_wdata    ),
    .ack_o        ( sys_ack      ),
    .rdata_o      ( sys_rdata    ),
    .err_o        ( sys_err      ),
    .timer_irq_o  ( timer_irq_o  ),
    .ipi_o        ( ipi_o        ),
    .exit_o       ( exit_o       ),
    .exit_valid_o ( exit_valid_o )
  );

endmodule

/* source/sys_regs.sv */
// --------------------
// System registers with core-local timer, software interrupt and tohost word
// mtime counts rising edges of the real-time clock input
// --------------------

`timescale 1ns/100ps
`include "harness_config.svh"

module sys_regs (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       rtc_i,
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [`HARNESS_ADDR_W-1:0] addr_i,
  input  logic [`HARNESS_DATA_W-1:0] wdata_i,
  output logic                       ack_o,
  output logic [`HARNESS_DATA_W-1:0] rdata_o,
  output logic                       err_o,
  output logic                       timer_irq_o,
  output logic                       ipi_o,
  output logic [`HARNESS_DATA_W-2:0] exit_o,
  output logic                       exit_valid_o
);

  import harness_pkg::*;

  bus_addr_u                  addr;
  tohost_u                    wr_host;
  tohost_u                    tohost_q;
  logic [2:0]                 rtc_q;
  logic                       rtc_rise;
  logic                       msip_q;
  logic [`HARNESS_DATA_W-1:0] mtime_q;
  logic [`HARNESS_DATA_W-1:0] mtimecmp_q;
  logic [`HARNESS_DATA_W-1:0] rd_data;

  assign addr.word   = addr_i;
  assign wr_host.raw = wdata_i;
  assign ipi_o       = msip_q;
  assign exit_o      = tohost_q.f.code;

  // --------------------
  // Timer
  // --------------------
  // Two synchroniser flops, the third one finds the edge
  assign rtc_rise = rtc_q[1] & ~rtc_q[2];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_q       <= '0;
      mtime_q     <= '0;
      timer_irq_o <= 1'b0;
    end else begin
      rtc_q       <= {rtc_q[1:0], rtc_i};
      timer_irq_o <= (mtime_q >= mtimecmp_q);
      if (rtc_rise) begin
        mtime_q <= mtime_q + 1'b1;
      end
    end
  end

  // --------------------
  // Register access
  // --------------------
  always_comb begin
    rd_data = '0;
    case (addr.f.index)
      `HARNESS_OFS_MSIP:     rd_data[0] = msip_q;
      `HARNESS_OFS_MTIMECMP: rd_data    = mtimecmp_q;
      `HARNESS_OFS_MTIME:    rd_data    = mtime_q;
      `HARNESS_OFS_TOHOST:   rd_data    = tohost_q.raw;
      default:               rd_data    = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_o        <= 1'b0;
      err_o        <= 1'b0;
      msip_q       <= 1'b0;
      mtimecmp_q   <= '1;
      tohost_q     <= '0;
      exit_valid_o <= 1'b0;
    end else begin
      ack_o <= req_i;
      if (req_i && !ack_o) begin
        err_o <= 1'b0;
        case (addr.f.index)
          `HARNESS_OFS_MSIP: begin
            if (we_i) msip_q <= wdata_i[0];
          end
          `HARNESS_OFS_MTIMECMP: begin
            if (we_i) mtimecmp_q <= wdata_i;
          end
          // mtime is read-only from the bus
          `HARNESS_OFS_MTIME: ;
          `HARNESS_OFS_TOHOST: begin
            if (we_i && wr_host.f.done) begin
              tohost_q     <= wr_host;
              exit_valid_o <= 1'b1;
            end
          end
          default: err_o <= 1'b1;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !ack_o) begin
      rdata_o <= we_i ? '0 : rd_data;
    end
  end

  // End of test is sticky until the next system reset
  a_exit_sticky : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    exit_valid_o |=> exit_valid_o
  );

endmodule

/* source/sram_bank.sv */
// --------------------
// Word-wide SRAM target with byte enables
// Higher index bits alias onto the configured depth
// --------------------

`timescale 1ns/100ps
`include "harness_config.svh"

module sram_bank #(
  parameter int unsigned depth = `HARNESS_SRAM_WORDS
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [`HARNESS_ADDR_W-1:0] addr_i,
  input  logic [`HARNESS_DATA_W-1:0] wdata_i,
  input  logic [`HARNESS_BE_W-1:0]   be_i,
  output logic                       ack_o,
  output logic [`HARNESS_DATA_W-1:0] rdata_o,
  output logic                       err_o
);

  import harness_pkg::*;

  localparam int unsigned mem_aw = $clog2(depth);

  bus_addr_u                  addr;
  logic [mem_aw-1:0]          word_idx;
  logic [`HARNESS_DATA_W-1:0] mem_q [depth];

  assign addr.word = addr_i;
  assign word_idx  = addr.f.index[mem_aw-1:0];
  assign err_o     = 1'b0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= req_i;
    end
  end

  // Access happens once, on the edge that raises ack
  always_ff @(posedge clk_i) begin
    if (req_i && !ack_o) begin
      if (we_i) begin
        for (int b = 0; b < `HARNESS_BE_W; b++) begin
          if (be_i[b]) begin
            mem_q[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
        rdata_o <= '0;
      end else begin
        rdata_o <= mem_q[word_idx];
      end
    end
  end

endmodule

/* source/boot_rom.sv */
// --------------------
// Boot ROM target holding the fixed boot image
// Reads return one image word, writes are refused with an error
// --------------------

`timescale 1ns/100ps
`include "harness_config.svh"

module boot_rom (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [`HARNESS_ADDR_W-1:0] addr_i,
  output logic                       ack_o,
  output logic [`HARNESS_DATA_W-1:0] rdata_o,
  output logic                       err_o
);

  import harness_pkg::*;

  localparam int unsigned rom_aw = $clog2(`HARNESS_ROM_WORDS);

  bus_addr_u         addr;
  logic [rom_aw-1:0] word_idx;

  assign addr.word = addr_i;
  // Image repeats across the region
  assign word_idx  = addr.f.index[rom_aw-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
    end else begin
      ack_o <= req_i;
      if (req_i && !ack_o) begin
        err_o <= we_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !ack_o) begin
      rdata_o <= we_i ? '0 : BOOT_IMAGE[word_idx];
    end
  end

endmodule

/* source/bus_demux.sv */
// --------------------
// Region decoder for the four-phase bus
// Routes each transfer to one target and answers GPIO or unmapped regions with an error
// --------------------

`timescale 1ns/100ps
`include "harness_config.svh"

module bus_demux (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [`HARNESS_ADDR_W-1:0] addr_i,
  input  logic [`HARNESS_DATA_W-1:0] wdata_i,
  input  logic [`HARNESS_BE_W-1:0]   be_i,
  output logic                       ack_o,
  output logic [`HARNESS_DATA_W-1:0] rdata_o,
  output logic                       err_o,
  output logic                       rom_req_o,
  input  logic                       rom_ack_i,
  input  logic [`HARNESS_DATA_W-1:0] rom_rdata_i,
  input  logic                       rom_err_i,
  output logic                       sram_req_o,
  input  logic                       sram_ack_i,
  input  logic [`HARNESS_DATA_W-1:0] sram_rdata_i,
  input  logic                       sram_err_i,
  output logic                       sys_req_o,
  input  logic                       sys_ack_i,
  input  logic [`HARNESS_DATA_W-1:0] sys_rdata_i,
  input  logic                       sys_err_i,
  output logic                       we_o,
  output logic [`HARNESS_ADDR_W-1:0] addr_o,
  output logic [`HARNESS_DATA_W-1:0] wdata_o,
  output logic [`HARNESS_BE_W-1:0]   be_o
);

  import harness_pkg::*;

  bus_addr_u addr;
  logic      rom_sel;
  logic      sram_sel;
  logic      sys_sel;
  logic      err_sel;
  logic      err_ack_q;

  assign addr.word = addr_i;

  // --------------------
  // Decode
  // --------------------
  always_comb begin
    rom_sel  = 1'b0;
    sram_sel = 1'b0;
    sys_sel  = 1'b0;
    err_sel  = 1'b0;
    case (addr.f.region)
      `HARNESS_REGION_ROM:  rom_sel  = 1'b1;
      `HARNESS_REGION_SYS:  sys_sel  = 1'b1;
      `HARNESS_REGION_SRAM: sram_sel = 1'b1;
      // GPIO has no device behind it
      `HARNESS_REGION_GPIO: err_sel  = 1'b1;
      default:              err_sel  = 1'b1;
    endcase
  end

  assign rom_req_o  = req_i & rom_sel;
  assign sram_req_o = req_i & sram_sel;
  assign sys_req_o  = req_i & sys_sel;

  // Shared request fields
  assign we_o    = we_i;
  assign addr_o  = addr_i;
  assign wdata_o = wdata_i;
  assign be_o    = be_i;

  // Error responder, same timing as a real target
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_ack_q <= 1'b0;
    end else begin
      err_ack_q <= req_i & err_sel;
    end
  end

  // --------------------
  // Response return
  // --------------------
  // Only the addressed target can be acking, so the response is an OR
  assign ack_o   = rom_ack_i | sram_ack_i | sys_ack_i | err_ack_q;
  assign err_o   = (rom_ack_i & rom_err_i) | (sram_ack_i & sram_err_i) |
                   (sys_ack_i & sys_err_i) | err_ack_q;
  assign rdata_o = ({`HARNESS_DATA_W{rom_ack_i}}  & rom_rdata_i)  |
                   ({`HARNESS_DATA_W{sram_ack_i}} & sram_rdata_i) |
                   ({`HARNESS_DATA_W{sys_ack_i}}  & sys_rdata_i);

  // One request out and one responder answering at a time
  a_one_target : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0({rom_req_o, sram_req_o, sys_req_o}) &&
    $onehot0({rom_ack_i, sram_ack_i, sys_ack_i, err_ack_q})
  );

endmodule

/* source/reset_debug_ctrl.sv */
// --------------------
// System reset generation and debug request gating
// Debug stays blocked for a fixed hold-off after power-on reset
// --------------------

`timescale 1ns/100ps
`include "harness_config.svh"

module reset_debug_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  input  logic debug_req_i,
  input  logic debug_en_i,
  output logic sys_rst_no,
  output logic debug_req_o
);

  localparam int unsigned cnt_w = $clog2(`HARNESS_DEBUG_HOLDOFF + 1);

  logic             rst_comb_n;
  logic [1:0]       rst_sync_q;
  logic [cnt_w-1:0] hold_cnt_q;

  // Asserts at once, releases on the second edge
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      rst_sync_q <= '0;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = rst_sync_q[1];

  // Hold-off counter, cleared by power-on reset only
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_cnt_q <= cnt_w'(`HARNESS_DEBUG_HOLDOFF);
    end else if (hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (hold_cnt_q == '0) & debug_en_i & debug_req_i;

  // Once open, the debug gate stays open until the next power-on reset
  a_holdoff_done_sticky : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (hold_cnt_q == '0) |=> (hold_cnt_q == '0)
  );

endmodule

/* source/harness_pkg.sv */
// --------------------
// Shared types of the harness and the boot image
// Import inside a module body where the address or tohost views are needed
// --------------------

`include "harness_config.svh"

package harness_pkg;

  // Bus address as a flat word or as region/index/byte fields
  typedef union packed {
    logic [`HARNESS_ADDR_W-1:0] word;
    struct packed {
      logic [`HARNESS_REGION_W-1:0] region;
      logic [`HARNESS_INDEX_W-1:0]  index;
      logic [`HARNESS_BYTE_W-1:0]   offset;
    } f;
  } bus_addr_u;

  // End-of-test word, exit code above the done flag
  typedef union packed {
    logic [`HARNESS_DATA_W-1:0] raw;
    struct packed {
      logic [`HARNESS_DATA_W-2:0] code;
      logic                       done;
    } f;
  } tohost_u;

  // Boot image
  // Loads the hart id, jumps through a pointer, then parks in wfi
  localparam logic [`HARNESS_DATA_W-1:0] BOOT_IMAGE [`HARNESS_ROM_WORDS] = '{
    32'h0000_0297, 32'h0102_8593, 32'hf140_2573, 32'h0182_a283,
    32'h0002_8067, 32'h0000_0013, 32'h0000_0013, 32'h0000_0013,
    32'h1050_0073, 32'hffdf_f06f, 32'h0000_0000, 32'h0000_0000,
    32'h8000_0000, 32'h0000_0000, 32'hdead_beef, 32'h0bad_c0de
  };

endpackage

/* source/harness_config.svh */
// --------------------
// Build constants for the simulation harness
// Included by the package, every RTL file and the testbench
// --------------------

`ifndef HARNESS_CONFIG_SVH
`define HARNESS_CONFIG_SVH

// Bus widths
`define HARNESS_ADDR_W      16
`define HARNESS_DATA_W      32
`define HARNESS_BE_W        4
`define HARNESS_REGION_W    4
`define HARNESS_INDEX_W     10
`define HARNESS_BYTE_W      2

// Region codes in the top address field
`define HARNESS_REGION_ROM  4'h0
`define HARNESS_REGION_SYS  4'h2
`define HARNESS_REGION_GPIO 4'h4
`define HARNESS_REGION_SRAM 4'h8

// Memory depths in words
`define HARNESS_ROM_WORDS   16
`define HARNESS_SRAM_WORDS  256

// Word offsets inside the SYS region
`define HARNESS_OFS_MSIP     0
`define HARNESS_OFS_MTIMECMP 1
`define HARNESS_OFS_MTIME    2
`define HARNESS_OFS_TOHOST   3

// Cycles after power-on reset with debug requests held off
`define HARNESS_DEBUG_HOLDOFF 500

`endif
